// ==== verilog/core_shell_pkg.sv ====
// Arcade board shell shared definitions
// Host word widths, joystick bit map and the bundles passed between blocks
package core_shell_pkg;

    ////////////////////////////////////////
    // Host interface
    ////////////////////////////////////////

    // Option status word from the host controller
    localparam int STATUS_W = 129;

    // Download index reserved for DIP switch banks
    localparam logic [7:0] DIP_INDEX = 8'd254;
    localparam int DIP_ADDR_W = 25;

    // Buttons per player handed to the game logic
    localparam int PLAYER_BITS = 10;

    // Extra buttons sitting above the player bits in a joystick word
    localparam int JOY_START  = 10;
    localparam int JOY_COIN   = 11;
    localparam int JOY_START2 = 12;
    localparam int JOY_PAUSE  = 13;

    ////////////////////////////////////////
    // Memory ports
    ////////////////////////////////////////

    localparam int SDR_ADDR_W = 25;
    localparam int DDR_ADDR_W = 29;

    // Decoded option settings
    typedef struct packed {
        logic [1:0] aspect;
        logic [2:0] fx;
        logic [1:0] scale;
        logic       pause_in_menu;
        logic       autosave;
        logic       vertical;
        logic       squished;
        logic       cpu_turbo;
        logic [4:0] hoffset;
        logic [4:0] voffset;
        logic [1:0] sample_attn;
        logic [3:0] layer_en;
        logic       solid_sprites;
    } option_t;

    // Cabinet inputs as seen by the game logic
    typedef struct packed {
        logic [PLAYER_BITS-1:0] p1;
        logic [PLAYER_BITS-1:0] p2;
        logic [PLAYER_BITS-1:0] p3;
        logic [PLAYER_BITS-1:0] p4;
        logic [3:0]             start;
        logic [3:0]             coin;
        logic                   pause;
    } player_t;

    // One SDRAM channel request, byte addressed
    typedef struct packed {
        logic [SDR_ADDR_W-1:0] addr;
        logic [15:0]           wdata;
        logic [1:0]            be;
        logic                  rnw;
        logic                  req;
    } sdr_port_t;

    // DDR command path, 64-bit words
    typedef struct packed {
        logic [7:0]            burstcnt;
        logic [DDR_ADDR_W-1:0] addr;
        logic                  rd;
        logic [7:0]            be;
        logic                  we;
    } ddr_cmd_t;

endpackage

// ==== verilog/option_regs.sv ====
// Option registers for the arcade shell
// Splits the host status word into settings, keeps the DIP switch banks
// loaded over the download stream and builds the core reset
`timescale 1ns/10ps

module option_regs #(
    parameter int DIP_BANKS = 8
) (
    input  logic                                 clk_sys,
    input  logic                                 rst_n,

    input  logic [core_shell_pkg::STATUS_W-1:0]   status,
    input  logic [1:0]                           buttons,

    // Download stream
    input  logic                                 ioctl_wr,
    input  logic [7:0]                           ioctl_index,
    input  logic [core_shell_pkg::DIP_ADDR_W-1:0] ioctl_addr,
    input  logic [7:0]                           ioctl_dout,

    input  logic                                 rom_load_busy,

    output core_shell_pkg::option_t              options,
    output logic [DIP_BANKS-1:0][7:0]            dip_sw,
    output logic                                 core_rst_n
);

    logic dip_wr;
    logic rst_req;

    ////////////////////////////////////////
    // Option decode
    ////////////////////////////////////////

    always_comb begin
        options.aspect        = status[2:1];
        options.fx            = status[31:29];
        options.scale         = status[6:5];
        options.pause_in_menu = status[7];
        options.autosave      = status[8];
        options.vertical      = status[10];
        options.squished      = status[11];
        options.cpu_turbo     = status[16];
        options.hoffset       = status[21:17];
        options.voffset       = status[26:22];
        options.sample_attn   = status[28:27];
        // Host menu stores layer disables
        options.layer_en      = ~status[67:64];
        options.solid_sprites = status[68];
    end

    ////////////////////////////////////////
    // DIP switch banks
    ////////////////////////////////////////

    // One byte per bank, bytes past the last bank are dropped
    assign dip_wr = ioctl_wr
                 && (ioctl_index == core_shell_pkg::DIP_INDEX)
                 && (ioctl_addr < DIP_BANKS);

    // Switches are active low so the idle value is all ones
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            dip_sw <= '1;
        end else if (dip_wr) begin
            for (int b = 0; b < DIP_BANKS; b++) begin
                if (ioctl_addr == b) begin
                    dip_sw[b] <= ioctl_dout;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Core reset
    ////////////////////////////////////////

    // Menu reset, user button, or a ROM load in progress
    assign rst_req = status[0] | buttons[1] | rom_load_busy;

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            core_rst_n <= 1'b0;
        end else begin
            core_rst_n <= ~rst_req;
        end
    end

endmodule

// ==== verilog/player_inputs.sv ====
// Cabinet input merge
// ORs keyboard and joystick words per player and maps the start, coin
// and pause buttons, registered once on the system clock
`timescale 1ns/10ps

module player_inputs (
    input  logic                    clk_sys,
    input  logic                    core_rst_n,

    input  logic [15:0]             joy_p1,
    input  logic [15:0]             joy_p2,
    input  logic [15:0]             joy_p3,
    input  logic [15:0]             joy_p4,

    input  logic [15:0]             key_p1,
    input  logic [15:0]             key_p2,
    input  logic [15:0]             key_p3,
    input  logic [15:0]             key_p4,

    input  logic [3:0]              key_start,
    input  logic [3:0]              key_coin,
    input  logic                    key_pause,

    output core_shell_pkg::player_t players
);

    localparam int PB = core_shell_pkg::PLAYER_BITS;

    logic [15:0]             m_p1;
    logic [15:0]             m_p2;
    logic [15:0]             m_p3;
    logic [15:0]             m_p4;
    logic [15:0]             joy_any;
    core_shell_pkg::player_t players_nxt;

    assign m_p1 = key_p1 | joy_p1;
    assign m_p2 = key_p2 | joy_p2;
    assign m_p3 = key_p3 | joy_p3;
    assign m_p4 = key_p4 | joy_p4;

    // Shared buttons can come from any pad
    assign joy_any = joy_p1 | joy_p2 | joy_p3 | joy_p4;

    always_comb begin
        players_nxt.p1 = m_p1[PB-1:0];
        players_nxt.p2 = m_p2[PB-1:0];
        players_nxt.p3 = m_p3[PB-1:0];
        players_nxt.p4 = m_p4[PB-1:0];

        players_nxt.start[0] = joy_p1[core_shell_pkg::JOY_START] | key_start[0];
        // Second start button on any pad also starts player 2
        players_nxt.start[1] = joy_p2[core_shell_pkg::JOY_START]
                             | joy_any[core_shell_pkg::JOY_START2]
                             | key_start[1];
        players_nxt.start[2] = joy_p3[core_shell_pkg::JOY_START] | key_start[2];
        players_nxt.start[3] = joy_p4[core_shell_pkg::JOY_START] | key_start[3];

        // Single coin slot
        players_nxt.coin = {3'b000, joy_any[core_shell_pkg::JOY_COIN] | (|key_coin)};

        players_nxt.pause = joy_any[core_shell_pkg::JOY_PAUSE] | key_pause;
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (!core_rst_n) begin
            players <= '0;
        end else begin
            players <= players_nxt;
        end
    end

endmodule

// ==== verilog/rom_port_mux.sv ====
// Shared memory port select
// While a ROM load runs the loader owns the SDRAM channel and the DDR
// command path, otherwise the CPU and the rotation buffer do
`timescale 1ns/10ps

module rom_port_mux (
    input  logic                                  rom_load_busy,

    // Loader side of the SDRAM channel
    input  core_shell_pkg::sdr_port_t             rom_sdr,

    // CPU read side of the SDRAM channel
    input  logic [core_shell_pkg::SDR_ADDR_W-1:0] cpu_addr,
    input  logic                                  cpu_req,

    input  logic                                  sdr_rdy,

    input  core_shell_pkg::ddr_cmd_t              rom_ddr,
    input  core_shell_pkg::ddr_cmd_t              rotate_ddr,

    output core_shell_pkg::sdr_port_t             sdr,
    output logic                                  cpu_rdy,
    output logic                                  rom_rdy,
    output core_shell_pkg::ddr_cmd_t              ddr
);

    ////////////////////////////////////////
    // SDRAM channel
    ////////////////////////////////////////

    always_comb begin
        // Write data only matters for loader writes
        sdr.wdata = rom_sdr.wdata;

        if (rom_load_busy) begin
            sdr.addr = rom_sdr.addr;
            sdr.be   = rom_sdr.be;
            sdr.rnw  = 1'b0;
            sdr.req  = rom_sdr.req;
        end else begin
            // CPU only reads program data
            sdr.addr = cpu_addr;
            sdr.be   = 2'b00;
            sdr.rnw  = 1'b1;
            sdr.req  = cpu_req;
        end
    end

    // Only the current owner is requesting, so both can watch the one ready
    assign cpu_rdy = sdr_rdy;
    assign rom_rdy = sdr_rdy;

    ////////////////////////////////////////
    // DDR command path
    ////////////////////////////////////////

    // Rotation buffer gets DDR back when the load finishes
    always_comb begin
        if (rom_load_busy) begin
            ddr = rom_ddr;
        end else begin
            ddr = rotate_ddr;
        end
    end

endmodule

// ==== verilog/video_aspect.sv ====
// Video aspect ratio select
// Gives the scaler its aspect numerator and denominator from the menu
`timescale 1ns/10ps

module video_aspect (
    input  core_shell_pkg::option_t options,

    output logic [11:0]             arx,
    output logic [11:0]             ary
);

    always_comb begin
        if (options.aspect == 2'd0) begin
            // Native ratio, swapped for a rotated monitor
            if (options.vertical) begin
                arx = 12'd7;
                ary = 12'd10;
            end else begin
                arx = 12'd10;
                ary = 12'd7;
            end
        end else begin
            // Full screen or custom ratio slot, ary of zero tells the scaler
            arx = 12'(options.aspect - 2'd1);
            ary = 12'd0;
        end
    end

endmodule

// ==== verilog/core_shell_top.sv ====
// Arcade board shell top level
// Ties option decode, input merge, memory port sharing and aspect select
// together between the host controller and the game logic
`timescale 1ns/10ps

module core_shell_top #(
    parameter int DIP_BANKS = 8
) (
    input  logic                                  clk_sys,
    input  logic                                  rst_n,

    // Host controller
    input  logic [core_shell_pkg::STATUS_W-1:0]    status,
    input  logic [1:0]                            buttons,
    input  logic                                  ioctl_wr,
    input  logic [7:0]                            ioctl_index,
    input  logic [core_shell_pkg::DIP_ADDR_W-1:0]  ioctl_addr,
    input  logic [7:0]                            ioctl_dout,

    // Player inputs
    input  logic [15:0]                           joy_p1,
    input  logic [15:0]                           joy_p2,
    input  logic [15:0]                           joy_p3,
    input  logic [15:0]                           joy_p4,
    input  logic [15:0]                           key_p1,
    input  logic [15:0]                           key_p2,
    input  logic [15:0]                           key_p3,
    input  logic [15:0]                           key_p4,
    input  logic [3:0]                            key_start,
    input  logic [3:0]                            key_coin,
    input  logic                                  key_pause,

    // Memory users
    input  logic                                  rom_load_busy,
    input  core_shell_pkg::sdr_port_t             rom_sdr,
    input  logic [core_shell_pkg::SDR_ADDR_W-1:0] cpu_addr,
    input  logic                                  cpu_req,
    input  logic                                  sdr_rdy,
    input  core_shell_pkg::ddr_cmd_t              rom_ddr,
    input  core_shell_pkg::ddr_cmd_t              rotate_ddr,

    output core_shell_pkg::option_t               options,
    output logic [DIP_BANKS-1:0][7:0]             dip_sw,
    output logic                                  core_rst_n,
    output core_shell_pkg::player_t               players,
    output core_shell_pkg::sdr_port_t             sdr,
    output logic                                  cpu_rdy,
    output logic                                  rom_rdy,
    output core_shell_pkg::ddr_cmd_t              ddr,
    output logic [11:0]                           arx,
    output logic [11:0]                           ary
);

    option_regs #(
        .DIP_BANKS(DIP_BANKS)
    ) option_regs_inst (
        .clk_sys,
        .rst_n,
        .status,
        .buttons,
        .ioctl_wr,
        .ioctl_index,
        .ioctl_addr,
        .ioctl_dout,
        .rom_load_busy,
        .options,
        .dip_sw,
        .core_rst_n
    );

    // Inputs are held clear while the core sits in reset
    player_inputs player_inputs_inst (
        .clk_sys,
        .core_rst_n,
        .joy_p1,
        .joy_p2,
        .joy_p3,
        .joy_p4,
        .key_p1,
        .key_p2,
        .key_p3,
        .key_p4,
        .key_start,
        .key_coin,
        .key_pause,
        .players
    );

    rom_port_mux rom_port_mux_inst (
        .rom_load_busy,
        .rom_sdr,
        .cpu_addr,
        .cpu_req,
        .sdr_rdy,
        .rom_ddr,
        .rotate_ddr,
        .sdr,
        .cpu_rdy,
        .rom_rdy,
        .ddr
    );

    video_aspect video_aspect_inst (
        .options,
        .arx,
        .ary
    );

endmodule

// ==== verification/core_shell_assert.sv ====
// Arcade shell checker
// Reference model of the shell rules with concurrent assertions, bound to the top
`timescale 1ns/10ps

module core_shell_assert #(
    parameter int DIP_BANKS = 8
) (
    input logic                                  clk_sys,
    input logic                                  rst_n,
    input logic [core_shell_pkg::STATUS_W-1:0]   status,
    input logic [1:0]                            buttons,
    input logic                                  ioctl_wr,
    input logic [7:0]                            ioctl_index,
    input logic [core_shell_pkg::DIP_ADDR_W-1:0] ioctl_addr,
    input logic [7:0]                            ioctl_dout,
    input logic [15:0]                           joy_p1, joy_p2, joy_p3, joy_p4,
    input logic [15:0]                           key_p1, key_p2, key_p3, key_p4,
    input logic [3:0]                            key_start,
    input logic [3:0]                            key_coin,
    input logic                                  key_pause,
    input logic                                  rom_load_busy,
    input core_shell_pkg::sdr_port_t             rom_sdr,
    input logic [core_shell_pkg::SDR_ADDR_W-1:0] cpu_addr,
    input logic                                  cpu_req,
    input logic                                  sdr_rdy,
    input core_shell_pkg::ddr_cmd_t              rom_ddr, rotate_ddr,
    input core_shell_pkg::option_t               options,
    input logic [DIP_BANKS-1:0][7:0]             dip_sw,
    input logic                                  core_rst_n,
    input core_shell_pkg::player_t               players,
    input core_shell_pkg::sdr_port_t             sdr,
    input logic                                  cpu_rdy,
    input logic                                  rom_rdy,
    input core_shell_pkg::ddr_cmd_t              ddr,
    input logic [11:0]                           arx, ary
);

    int                        error_count = 0;
    logic [1:0]                primed = 2'b00;
    logic [DIP_BANKS-1:0][7:0] exp_dip_q;
    logic                      exp_rst_n_q;
    core_shell_pkg::player_t   exp_players;
    core_shell_pkg::player_t   exp_players_q;
    core_shell_pkg::option_t   exp_opt;
    logic [15:0]               joy_or;
    logic [28:0]               exp_sdr_bits;
    logic [11:0]               exp_arx;
    logic [11:0]               exp_ary;

    ////////////////////////////////////////
    // Expected values
    ////////////////////////////////////////

    assign joy_or = joy_p1 | joy_p2 | joy_p3 | joy_p4;

    always_comb begin
        exp_players.p1    = key_p1[9:0] | joy_p1[9:0];
        exp_players.p2    = key_p2[9:0] | joy_p2[9:0];
        exp_players.p3    = key_p3[9:0] | joy_p3[9:0];
        exp_players.p4    = key_p4[9:0] | joy_p4[9:0];
        exp_players.start = {joy_p4[10] | key_start[3], joy_p3[10] | key_start[2],
                             joy_p2[10] | joy_or[12] | key_start[1],
                             joy_p1[10] | key_start[0]};
        exp_players.coin  = {3'b000, joy_or[11] | (|key_coin)};
        exp_players.pause = joy_or[13] | key_pause;

        exp_opt = {status[2:1], status[31:29], status[6:5], status[7], status[8],
                   status[10], status[11], status[16], status[21:17], status[26:22],
                   status[28:27], ~status[67:64], status[68]};

        if (rom_load_busy) begin
            exp_sdr_bits = {rom_sdr.addr, rom_sdr.be, 1'b0, rom_sdr.req};
        end else begin
            exp_sdr_bits = {cpu_addr, 2'b00, 1'b1, cpu_req};
        end

        // Native 10 by 7, turned for a vertical monitor
        exp_arx = (status[2:1] == 2'd0) ? (status[10] ? 12'd7 : 12'd10) : status[2:1] - 1;
        exp_ary = (status[2:1] == 2'd0) ? (status[10] ? 12'd10 : 12'd7) : 12'd0;
    end

    always @(posedge clk_sys) begin
        primed        <= {primed[0], 1'b1};
        exp_rst_n_q   <= !(!rst_n || status[0] || buttons[1] || rom_load_busy);
        exp_players_q <= exp_rst_n_q ? exp_players : '0;
        if (!rst_n) begin
            exp_dip_q <= '1;
        end else if (ioctl_wr && ioctl_index == 8'd254 && ioctl_addr < DIP_BANKS) begin
            exp_dip_q[ioctl_addr] <= ioctl_dout;
        end
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    dip_check: assert property (@(posedge clk_sys) disable iff (!primed[1])
        dip_sw == exp_dip_q)
    else begin
        error_count++;
        $error("Mismatch dip_sw %h expected %h", dip_sw, exp_dip_q);
    end
    rst_check: assert property (@(posedge clk_sys) disable iff (!primed[1])
        core_rst_n == exp_rst_n_q)
    else begin
        error_count++;
        $error("Mismatch core_rst_n %h expected %h", core_rst_n, exp_rst_n_q);
    end
    player_check: assert property (@(posedge clk_sys) disable iff (!primed[1])
        players == exp_players_q)
    else begin
        error_count++;
        $error("Mismatch players %h expected %h", players, exp_players_q);
    end
    option_check: assert property (@(posedge clk_sys) options == exp_opt)
    else begin
        error_count++;
        $error("Mismatch options %h expected %h", options, exp_opt);
    end
    sdr_check: assert property (@(posedge clk_sys)
        {sdr.addr, sdr.be, sdr.rnw, sdr.req} == exp_sdr_bits)
    else begin
        error_count++;
        $error("Mismatch sdr %h expected %h",
            {sdr.addr, sdr.be, sdr.rnw, sdr.req}, exp_sdr_bits);
    end
    // Loader write data reaches the shared port while loading
    wdata_check: assert property (@(posedge clk_sys)
        rom_load_busy |-> sdr.wdata == rom_sdr.wdata)
    else begin
        error_count++;
        $error("Mismatch sdr.wdata %h expected %h", sdr.wdata, rom_sdr.wdata);
    end
    ddr_check: assert property (@(posedge clk_sys)
        ddr == (rom_load_busy ? rom_ddr : rotate_ddr))
    else begin
        error_count++;
        $error("Mismatch ddr %h expected %h", ddr,
            rom_load_busy ? rom_ddr : rotate_ddr);
    end
    rdy_check: assert property (@(posedge clk_sys) cpu_rdy == sdr_rdy && rom_rdy == sdr_rdy)
    else begin
        error_count++;
        $error("Mismatch cpu_rdy %h rom_rdy %h expected %h",
            cpu_rdy, rom_rdy, sdr_rdy);
    end
    aspect_check: assert property (@(posedge clk_sys) arx == exp_arx && ary == exp_ary)
    else begin
        error_count++;
        $error("Mismatch arx %h ary %h expected %h %h",
            arx, ary, exp_arx, exp_ary);
    end

endmodule

bind core_shell_top core_shell_assert #(.DIP_BANKS(DIP_BANKS)) core_shell_assert_inst (.*);

// ==== verification/core_shell_tb.sv ====
// Arcade shell testbench
// Random host, player and memory stimulus; the bound checker judges the results
`timescale 1ns/10ps

module core_shell_tb;

    logic                       clk_sys = 1'b0;
    logic                       rst_n;
    logic [128:0]               status;
    logic [1:0]                 buttons;
    logic                       ioctl_wr;
    logic [7:0]                 ioctl_index;
    logic [24:0]                ioctl_addr;
    logic [7:0]                 ioctl_dout;
    logic [15:0]                joy_p1, joy_p2, joy_p3, joy_p4;
    logic [15:0]                key_p1, key_p2, key_p3, key_p4;
    logic [3:0]                 key_start, key_coin;
    logic                       key_pause, rom_load_busy, cpu_req, sdr_rdy;
    logic [24:0]                cpu_addr;
    core_shell_pkg::sdr_port_t  rom_sdr, sdr;
    core_shell_pkg::ddr_cmd_t   rom_ddr, rotate_ddr, ddr;
    core_shell_pkg::option_t    options;
    core_shell_pkg::player_t    players;
    logic [7:0][7:0]            dip_sw;
    logic                       core_rst_n, cpu_rdy, rom_rdy;
    logic [11:0]                arx, ary;
    logic [31:0]                lfsr = 32'ha0da7590;

    core_shell_top #(.DIP_BANKS(8)) core_shell_top_inst (.*);

    always #5 clk_sys = ~clk_sys;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("** FAIL **");
        $fatal(1, "%s", why);
    endtask

    // Any assertion failure ends the run
    always @(negedge clk_sys) begin
        if (core_shell_top_inst.core_shell_assert_inst.error_count != 0) begin
            stop_with_failure("assertion check failed");
        end
    end

    task automatic wait_core_reset(input logic level);
        int n;
        n = 0;
        while (core_rst_n !== level) begin
            @(posedge clk_sys);
            n++;
            if (n > 20) begin
                stop_with_failure("core reset did not reach the expected level");
            end
        end
    endtask

    task automatic drive_random();
        logic [159:0] w;
        logic [63:0]  d;
        w = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
        // Reset sources each raised about one cycle in eight
        w[0] = (rand_bits(3) == 7);
        status        <= w[128:0];
        buttons       <= {rand_bits(3) == 7, rand_bits(1) == 1};
        rom_load_busy <= (rand_bits(3) == 7);
        ioctl_wr      <= rand_bits(1);
        ioctl_index   <= rand_bits(1) ? 8'd254 : rand_bits(8);
        ioctl_addr    <= rand_bits(4);
        ioctl_dout    <= rand_bits(8);
        {joy_p1, joy_p2} <= rand_bits(32);
        {joy_p3, joy_p4} <= rand_bits(32);
        {key_p1, key_p2} <= rand_bits(32);
        {key_p3, key_p4} <= rand_bits(32);
        {key_start, key_coin, key_pause} <= rand_bits(9);
        {cpu_req, sdr_rdy} <= rand_bits(2);
        cpu_addr <= rand_bits(25);
        d = {rand_bits(32), rand_bits(32)};
        rom_sdr    <= d[44:0];
        d = {rand_bits(32), rand_bits(32)};
        rom_ddr    <= d[46:0];
        d = {rand_bits(32), rand_bits(32)};
        rotate_ddr <= d[46:0];
    endtask

    initial begin
        rst_n <= 1'b0;
        {status, buttons, ioctl_wr, ioctl_index, ioctl_addr, ioctl_dout} <= '0;
        {joy_p1, joy_p2, joy_p3, joy_p4, key_p1, key_p2, key_p3, key_p4} <= '0;
        {key_start, key_coin, key_pause, rom_load_busy, cpu_req, sdr_rdy} <= '0;
        {cpu_addr, rom_sdr, rom_ddr, rotate_ddr} <= '0;
        repeat (8) @(posedge clk_sys);
        rst_n <= 1'b1;
        wait_core_reset(1'b1);

        ////////////////////////////////////////
        // Random traffic on every input
        ////////////////////////////////////////
        repeat (400) begin
            @(posedge clk_sys);
            drive_random();
        end

        // Each reset source on its own
        @(posedge clk_sys);
        {status[0], buttons[1], rom_load_busy} <= 3'b000;
        wait_core_reset(1'b1);
        for (int s = 0; s < 3; s++) begin
            @(posedge clk_sys);
            {status[0], buttons[1], rom_load_busy} <= 3'b001 << s;
            wait_core_reset(1'b0);
            @(posedge clk_sys);
            {status[0], buttons[1], rom_load_busy} <= 3'b000;
            wait_core_reset(1'b1);
        end
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);

        if (core_shell_top_inst.core_shell_assert_inst.error_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_with_failure("assertion check failed");
        end
    end

endmodule

// ==== verilog.f ====
verilog/core_shell_pkg.sv
verilog/option_regs.sv
verilog/player_inputs.sv
verilog/rom_port_mux.sv
verilog/video_aspect.sv
verilog/core_shell_top.sv
verification/core_shell_assert.sv
verification/core_shell_tb.sv
